// ==== include/synth_settings.svh ====
`ifndef SYNTH_SETTINGS_SVH
`define SYNTH_SETTINGS_SVH

// ========================================
// Clocking
// ========================================

// System clock in Hz
`define SYNTH_SYSTEM_CLOCK 50000000

// Target audio sample rate in Hz
`define SYNTH_SAMPLE_RATE 48000

// Clock cycles per sample tick, rounded to the nearest whole cycle (1042)
`define SYNTH_SAMPLE_DIVIDE ((`SYNTH_SYSTEM_CLOCK + `SYNTH_SAMPLE_RATE / 2) / `SYNTH_SAMPLE_RATE)

// ========================================
// Data widths
// ========================================

// Levels, samples and rates all share this width
`define SYNTH_LEVEL_WIDTH 16
`define SYNTH_LEVEL_MAX 65535

// Wishbone word address width
`define SYNTH_ADDR_WIDTH 3

`endif

// ==== src/envelope_pkg.sv ====
package envelope_pkg;

  // ========================================
  // ADSR envelope states
  // ========================================

  // IDLE holds the level at zero until the next note starts
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    ATTACK  = 3'd1,
    DECAY   = 3'd2,
    SUSTAIN = 3'd3,
    RELEASE = 3'd4
  } envelope_state_t;

endpackage : envelope_pkg

// ==== src/voice_reg_pkg.sv ====
`include "synth_settings.svh"

package voice_reg_pkg;

  // ========================================
  // Wishbone register map
  // ========================================

  typedef enum logic [`SYNTH_ADDR_WIDTH-1:0] {
    ATTACK_RATE   = 3'd0,
    DECAY_RATE    = 3'd1,
    SUSTAIN_LEVEL = 3'd2,
    RELEASE_RATE  = 3'd3,
    PHASE_STEP    = 3'd4,
    WAVEFORM      = 3'd5,
    NOTE          = 3'd6,
    STATUS        = 3'd7
  } voice_reg_addr_t;

  // Oscillator wave shapes
  typedef enum logic [1:0] {
    SAW      = 2'd0,
    SQUARE   = 2'd1,
    TRIANGLE = 2'd2
  } waveform_t;

endpackage : voice_reg_pkg

// ==== src/voice_registers.sv ====
`include "synth_settings.svh"

module voice_registers
  import envelope_pkg::*;
  import voice_reg_pkg::*;
(
  input  logic                          clock_50_000_000,
  input  logic                          reset_l,
  input  logic [`SYNTH_ADDR_WIDTH-1:0]  wb_adr,
  input  logic [`SYNTH_LEVEL_WIDTH-1:0] wb_dat_w,
  output logic [`SYNTH_LEVEL_WIDTH-1:0] wb_dat_r,
  input  logic                          wb_we,
  input  logic                          wb_stb,
  input  logic                          wb_cyc,
  output logic                          wb_ack,
  input  envelope_state_t               envelope_state,
  output logic [`SYNTH_LEVEL_WIDTH-1:0] attack_rate,
  output logic [`SYNTH_LEVEL_WIDTH-1:0] decay_rate,
  output logic [`SYNTH_LEVEL_WIDTH-1:0] sustain_level,
  output logic [`SYNTH_LEVEL_WIDTH-1:0] release_rate,
  output logic [`SYNTH_LEVEL_WIDTH-1:0] phase_step,
  output waveform_t                     waveform,
  output logic                          note_on,
  output logic                          note_off
);

  localparam int LEVEL_WIDTH = `SYNTH_LEVEL_WIDTH;

  voice_reg_addr_t reg_addr;
  waveform_t       waveform_code;
  logic            wb_request;
  logic            write_strobe;
  logic            note_write;
  logic            note_active;

  assign reg_addr = voice_reg_addr_t'(wb_adr);

  // A new request is a strobe inside a cycle that has not been acked yet
  assign wb_request   = wb_stb && wb_cyc && !wb_ack;
  assign write_strobe = wb_request && wb_we;

  // The host holds its lines through the ack cycle, so the note pulse
  // can be decoded from them one cycle later
  assign note_write = wb_ack && wb_we && (reg_addr == NOTE);

  // Gate is open while the envelope has not been released
  assign note_active = (envelope_state == ATTACK) || (envelope_state == DECAY) ||
                       (envelope_state == SUSTAIN);

  // ========================================
  // Bus handshake
  // ========================================

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_request;
    end
  end

  // Unknown wave codes fall back to a sawtooth
  always_comb begin
    case (wb_dat_w[1:0])
      SQUARE:   waveform_code = SQUARE;
      TRIANGLE: waveform_code = TRIANGLE;
      default:  waveform_code = SAW;
    endcase
  end

  // ========================================
  // Setting registers
  // ========================================

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      attack_rate   <= '0;
      decay_rate    <= '0;
      sustain_level <= '0;
      release_rate  <= '0;
      phase_step    <= '0;
      waveform      <= SAW;
    end else if (write_strobe) begin
      case (reg_addr)
        ATTACK_RATE:   attack_rate   <= wb_dat_w;
        DECAY_RATE:    decay_rate    <= wb_dat_w;
        SUSTAIN_LEVEL: sustain_level <= wb_dat_w;
        RELEASE_RATE:  release_rate  <= wb_dat_w;
        PHASE_STEP:    phase_step    <= wb_dat_w;
        WAVEFORM:      waveform      <= waveform_code;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      note_on  <= 1'b0;
      note_off <= 1'b0;
    end else begin
      note_on  <= note_write && wb_dat_w[0];
      note_off <= note_write && !wb_dat_w[0];
    end
  end

  // Read data is valid whenever ack is high
  always_comb begin
    case (reg_addr)
      ATTACK_RATE:   wb_dat_r = attack_rate;
      DECAY_RATE:    wb_dat_r = decay_rate;
      SUSTAIN_LEVEL: wb_dat_r = sustain_level;
      RELEASE_RATE:  wb_dat_r = release_rate;
      PHASE_STEP:    wb_dat_r = phase_step;
      WAVEFORM:      wb_dat_r = {{(LEVEL_WIDTH - $bits(waveform_t)){1'b0}}, waveform};
      NOTE:          wb_dat_r = {{(LEVEL_WIDTH - 1){1'b0}}, note_active};
      default: begin
        wb_dat_r = {{(LEVEL_WIDTH - $bits(envelope_state_t)){1'b0}}, envelope_state};
      end
    endcase
  end

endmodule : voice_registers

// ==== src/envelope_generator.sv ====
`include "synth_settings.svh"

module envelope_generator
  import envelope_pkg::*;
(
  input  logic                          clock_50_000_000,
  input  logic                          reset_l,
  input  logic [`SYNTH_LEVEL_WIDTH-1:0] attack_rate,
  input  logic [`SYNTH_LEVEL_WIDTH-1:0] decay_rate,
  input  logic [`SYNTH_LEVEL_WIDTH-1:0] sustain_level,
  input  logic [`SYNTH_LEVEL_WIDTH-1:0] release_rate,
  input  logic                          note_on,
  input  logic                          note_off,
  output logic                          sample_tick,
  output logic [`SYNTH_LEVEL_WIDTH-1:0] envelope_level,
  output envelope_state_t               envelope_state,
  output logic                          envelope_end
);

  localparam int LEVEL_WIDTH      = `SYNTH_LEVEL_WIDTH;
  localparam int TICK_COUNT_WIDTH = $clog2(`SYNTH_SAMPLE_DIVIDE);

  localparam logic [TICK_COUNT_WIDTH-1:0] TICK_LAST =
    TICK_COUNT_WIDTH'(`SYNTH_SAMPLE_DIVIDE - 1);
  localparam logic [LEVEL_WIDTH-1:0] LEVEL_MAX = LEVEL_WIDTH'(`SYNTH_LEVEL_MAX);

  logic [TICK_COUNT_WIDTH-1:0] tick_count;
  logic [LEVEL_WIDTH:0]        attack_sum;
  logic [LEVEL_WIDTH:0]        decay_floor;

  // One extra bit catches the carry out of the attack step
  assign attack_sum = {1'b0, envelope_level} + {1'b0, attack_rate};

  // Decay lands on sustain once a full step would reach or pass it
  assign decay_floor = {1'b0, sustain_level} + {1'b0, decay_rate};

  // ========================================
  // Sample tick divider
  // ========================================

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      tick_count  <= '0;
      sample_tick <= 1'b0;
    end else if (note_on) begin
      // A new note starts a fresh sample period
      tick_count  <= '0;
      sample_tick <= 1'b0;
    end else if (tick_count == TICK_LAST) begin
      tick_count  <= '0;
      sample_tick <= 1'b1;
    end else begin
      tick_count  <= tick_count + 1'b1;
      sample_tick <= 1'b0;
    end
  end

  // ========================================
  // ADSR state machine
  // ========================================

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      envelope_state <= IDLE;
      envelope_level <= '0;
      envelope_end   <= 1'b0;
    end else begin
      envelope_end <= 1'b0;
      if (note_on) begin
        envelope_state <= ATTACK;
        envelope_level <= '0;
      end else if (note_off && envelope_state != IDLE) begin
        // Release starts from wherever the level is now
        envelope_state <= RELEASE;
      end else if (sample_tick) begin
        case (envelope_state)
          ATTACK: begin
            if (attack_sum >= {1'b0, LEVEL_MAX}) begin
              envelope_level <= LEVEL_MAX;
              envelope_state <= DECAY;
            end else begin
              envelope_level <= attack_sum[LEVEL_WIDTH-1:0];
            end
          end
          DECAY: begin
            if ({1'b0, envelope_level} <= decay_floor) begin
              envelope_level <= sustain_level;
              envelope_state <= SUSTAIN;
            end else begin
              envelope_level <= envelope_level - decay_rate;
            end
          end
          SUSTAIN: begin
            envelope_level <= sustain_level;
          end
          RELEASE: begin
            if (envelope_level <= release_rate) begin
              envelope_level <= '0;
              envelope_state <= IDLE;
              envelope_end   <= 1'b1;
            end else begin
              envelope_level <= envelope_level - release_rate;
            end
          end
          default: begin
            envelope_level <= '0;
          end
        endcase
      end
    end
  end

endmodule : envelope_generator

// ==== src/tone_oscillator.sv ====
`include "synth_settings.svh"

module tone_oscillator
  import voice_reg_pkg::*;
(
  input  logic                          clock_50_000_000,
  input  logic                          reset_l,
  input  logic                          sample_tick,
  input  logic [`SYNTH_LEVEL_WIDTH-1:0] phase_step,
  input  waveform_t                     waveform,
  input  logic [`SYNTH_LEVEL_WIDTH-1:0] envelope_level,
  output logic [`SYNTH_LEVEL_WIDTH-1:0] sample,
  output logic                          sample_valid
);

  localparam int LEVEL_WIDTH = `SYNTH_LEVEL_WIDTH;
  localparam logic [LEVEL_WIDTH-1:0] LEVEL_MAX = LEVEL_WIDTH'(`SYNTH_LEVEL_MAX);

  logic [LEVEL_WIDTH-1:0]   phase;
  logic [LEVEL_WIDTH-1:0]   phase_doubled;
  logic [LEVEL_WIDTH-1:0]   wave;
  logic [2*LEVEL_WIDTH-1:0] scaled;

  assign phase_doubled = {phase[LEVEL_WIDTH-2:0], 1'b0};

  // ========================================
  // Wave shaping
  // ========================================

  always_comb begin
    case (waveform)
      SQUARE:   wave = phase[LEVEL_WIDTH-1] ? LEVEL_MAX : '0;
      // Second half of the cycle runs the doubled phase back down
      TRIANGLE: wave = phase[LEVEL_WIDTH-1] ? ~phase_doubled : phase_doubled;
      default:  wave = phase;
    endcase
  end

  // Full level passes the wave almost unchanged, zero level silences it
  assign scaled = wave * envelope_level;

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      phase        <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= sample_tick;
      if (sample_tick) begin
        phase <= phase + phase_step;
      end
    end
  end

  always_ff @(posedge clock_50_000_000) begin
    if (sample_tick) begin
      sample <= scaled[2*LEVEL_WIDTH-1:LEVEL_WIDTH];
    end
  end

endmodule : tone_oscillator

// ==== src/synth_voice.sv ====
`include "synth_settings.svh"

module synth_voice
  import envelope_pkg::*;
  import voice_reg_pkg::*;
(
  input  logic                          clock_50_000_000,
  input  logic                          reset_l,
  input  logic [`SYNTH_ADDR_WIDTH-1:0]  wb_adr,
  input  logic [`SYNTH_LEVEL_WIDTH-1:0] wb_dat_w,
  output logic [`SYNTH_LEVEL_WIDTH-1:0] wb_dat_r,
  input  logic                          wb_we,
  input  logic                          wb_stb,
  input  logic                          wb_cyc,
  output logic                          wb_ack,
  output logic [`SYNTH_LEVEL_WIDTH-1:0] sample,
  output logic                          sample_valid,
  output logic [`SYNTH_LEVEL_WIDTH-1:0] envelope_level,
  output logic                          envelope_end
);

  logic [`SYNTH_LEVEL_WIDTH-1:0] attack_rate;
  logic [`SYNTH_LEVEL_WIDTH-1:0] decay_rate;
  logic [`SYNTH_LEVEL_WIDTH-1:0] sustain_level;
  logic [`SYNTH_LEVEL_WIDTH-1:0] release_rate;
  logic [`SYNTH_LEVEL_WIDTH-1:0] phase_step;
  waveform_t                     waveform;
  envelope_state_t               envelope_state;
  logic                          note_on;
  logic                          note_off;
  logic                          sample_tick;

  // Host side register file
  voice_registers voice_registers_inst (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .wb_adr           (wb_adr),
    .wb_dat_w         (wb_dat_w),
    .wb_dat_r         (wb_dat_r),
    .wb_we            (wb_we),
    .wb_stb           (wb_stb),
    .wb_cyc           (wb_cyc),
    .wb_ack           (wb_ack),
    .envelope_state   (envelope_state),
    .attack_rate      (attack_rate),
    .decay_rate       (decay_rate),
    .sustain_level    (sustain_level),
    .release_rate     (release_rate),
    .phase_step       (phase_step),
    .waveform         (waveform),
    .note_on          (note_on),
    .note_off         (note_off)
  );

  // The envelope also owns the sample tick for the oscillator
  envelope_generator envelope_generator_inst (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .attack_rate      (attack_rate),
    .decay_rate       (decay_rate),
    .sustain_level    (sustain_level),
    .release_rate     (release_rate),
    .note_on          (note_on),
    .note_off         (note_off),
    .sample_tick      (sample_tick),
    .envelope_level   (envelope_level),
    .envelope_state   (envelope_state),
    .envelope_end     (envelope_end)
  );

  tone_oscillator tone_oscillator_inst (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .sample_tick      (sample_tick),
    .phase_step       (phase_step),
    .waveform         (waveform),
    .envelope_level   (envelope_level),
    .sample           (sample),
    .sample_valid     (sample_valid)
  );

endmodule : synth_voice

// ==== verification/synth_voice_sva.sv ====
`include "synth_settings.svh"

module synth_voice_sva
  import envelope_pkg::*;
  import voice_reg_pkg::*;
(
  input logic                          clock_50_000_000,
  input logic                          reset_l,
  input logic                          wb_stb,
  input logic                          wb_cyc,
  input logic                          wb_ack,
  input logic                          note_on,
  input logic                          note_off,
  input logic                          sample_tick,
  input logic                          sample_valid,
  input logic [`SYNTH_LEVEL_WIDTH-1:0] sample,
  input logic [`SYNTH_LEVEL_WIDTH-1:0] attack_rate,
  input logic [`SYNTH_LEVEL_WIDTH-1:0] sustain_level,
  input logic [`SYNTH_LEVEL_WIDTH-1:0] phase_step,
  input waveform_t                     waveform,
  input logic [`SYNTH_LEVEL_WIDTH-1:0] envelope_level,
  input envelope_state_t               envelope_state,
  input logic                          envelope_end
);

  timeunit 1ns;
  timeprecision 1ps;

  int                            failure_count = 0;
  logic                          tick_full_saw;
  logic                          last_full_saw;
  logic [`SYNTH_LEVEL_WIDTH-1:0] last_sample;

  function automatic void record_violation(input string what);
    failure_count++;
    $error("Assertion violated: %s", what);
  endfunction

  // Attack climbs by the rate and stops at the ceiling
  function automatic logic [15:0] attack_target(input logic [15:0] level,
                                                input logic [15:0] rate);
    int sum;
    sum = int'(level) + int'(rate);
    return (sum >= `SYNTH_LEVEL_MAX) ? 16'(`SYNTH_LEVEL_MAX) : 16'(sum);
  endfunction

  // Full scale drops each sample by at most 1, so the step may be off by 1 either way
  function automatic logic saw_step_ok(input logic [15:0] previous, input logic [15:0] current,
                                       input logic [15:0] step);
    logic [15:0] offset;
    offset = current - previous - step + 16'd1;
    return offset <= 16'd2;
  endfunction

  // Remember which samples were taken in SAW mode at full level
  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      tick_full_saw <= 1'b0;
      last_full_saw <= 1'b0;
      last_sample   <= '0;
    end else begin
      if (sample_tick) begin
        tick_full_saw <= (envelope_level == `SYNTH_LEVEL_MAX) && (waveform == SAW);
      end
      if (sample_valid) begin
        last_full_saw <= tick_full_saw;
        last_sample   <= sample;
      end
    end
  end

  // ========================================
  // Bus and reset
  // ========================================

  assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    wb_ack |-> $past(wb_stb && wb_cyc && !wb_ack) ##1 !wb_ack)
    else record_violation("wb_ack without a new strobe or longer than one cycle");

  assert property (@(posedge clock_50_000_000)
    $rose(reset_l) |-> !wb_ack && !sample_valid && !envelope_end && envelope_level == '0)
    else record_violation("outputs not cleared by reset");

  // ========================================
  // Envelope
  // ========================================

  assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    sample_valid && $past(envelope_state == ATTACK && !note_on && !note_off)
    |-> envelope_level == attack_target($past(envelope_level), $past(attack_rate)))
    else record_violation("attack step does not match the attack rate");

  assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    envelope_state == DECAY |-> envelope_level >= sustain_level)
    else record_violation("decay fell below the sustain level");

  assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    sample_valid && $past(envelope_state == SUSTAIN && !note_on && !note_off)
    |-> envelope_level == $past(sustain_level))
    else record_violation("sustain does not hold the sustain level");

  assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    envelope_state == RELEASE |-> envelope_level <= $past(envelope_level))
    else record_violation("level rose during release");

  assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    envelope_state == IDLE && $past(envelope_state == RELEASE)
    |-> envelope_end && envelope_level == '0)
    else record_violation("release ended without envelope_end at level zero");

  assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    envelope_end |-> $past(envelope_state == RELEASE) ##1 !envelope_end)
    else record_violation("envelope_end outside the end of a release");

  assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    note_on |=> envelope_state == ATTACK && envelope_level == '0)
    else record_violation("note start did not restart the attack from zero");

  // ========================================
  // Samples
  // ========================================

  assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    sample_valid == $past(sample_tick))
    else record_violation("sample_valid not one cycle after the sample tick");

  assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    sample_valid && $past(envelope_level) == '0 |-> sample == '0)
    else record_violation("nonzero sample at level zero");

  assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    sample_valid && tick_full_saw && last_full_saw
    |-> saw_step_ok(last_sample, sample, phase_step))
    else record_violation("sawtooth step differs from the phase step");

endmodule : synth_voice_sva

bind synth_voice synth_voice_sva synth_voice_sva_inst (.*);

// ==== verification/synth_voice_tb.sv ====
`include "synth_settings.svh"

module synth_voice_tb
  import envelope_pkg::*;
  import voice_reg_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ACK_TIMEOUT    = 16;
  localparam int SAMPLE_TIMEOUT = 2 * `SYNTH_SAMPLE_DIVIDE + 8;
  localparam int END_TIMEOUT    = 64 * `SYNTH_SAMPLE_DIVIDE;
  localparam int STATE_TIMEOUT  = 100;

  logic                          clock_50_000_000;
  logic                          reset_l;
  logic [`SYNTH_ADDR_WIDTH-1:0]  wb_adr;
  logic [`SYNTH_LEVEL_WIDTH-1:0] wb_dat_w;
  logic [`SYNTH_LEVEL_WIDTH-1:0] wb_dat_r;
  logic                          wb_we;
  logic                          wb_stb;
  logic                          wb_cyc;
  logic                          wb_ack;
  logic [`SYNTH_LEVEL_WIDTH-1:0] sample;
  logic                          sample_valid;
  logic [`SYNTH_LEVEL_WIDTH-1:0] envelope_level;
  logic                          envelope_end;

  int          seed = 61244;
  int          test_errors;
  int          failed_tests;
  int          total_errors;
  int          assertion_mark;
  logic [15:0] attack_setting;
  logic [15:0] decay_setting;
  logic [15:0] sustain_setting;
  logic [15:0] release_setting;
  logic [15:0] step_setting;
  logic [15:0] sample_value;

  synth_voice synth_voice_inst (.*);

  initial begin
    clock_50_000_000 = 1'b0;
    forever begin
      #50 clock_50_000_000 = ~clock_50_000_000;
    end
  end

  // Rates stay between 2048 and 8191 so a whole note ends within the timeouts
  function automatic logic [15:0] random_rate();
    return 16'h0800 | (16'($random(seed)) & 16'h1FFF);
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("Timeout: no %s arrived within the wait limit at %0t ns", what, $time);
    $display("Test failed");
    $finish;
  endtask

  task automatic check_value(input string what, input logic [15:0] got,
                             input logic [15:0] expected);
    if (got !== expected) begin
      $display("Fail at %0t ns: %s is 0x%04h, expected 0x%04h", $time, what, got, expected);
      test_errors++;
    end
  endtask

  // ========================================
  // Wishbone host
  // ========================================

  task automatic bus_cycle(input voice_reg_addr_t addr, input logic write,
                           input logic [15:0] data_in, output logic [15:0] data_out);
    int   cycles;
    logic acked;
    acked    = 1'b0;
    data_out = '0;
    @(posedge clock_50_000_000);
    wb_adr   <= addr;
    wb_dat_w <= data_in;
    wb_we    <= write;
    wb_stb   <= 1'b1;
    wb_cyc   <= 1'b1;
    for (cycles = 0; cycles < ACK_TIMEOUT && !acked; cycles++) begin
      @(posedge clock_50_000_000);
      if (wb_ack) begin
        acked    = 1'b1;
        data_out = wb_dat_r;
      end
    end
    wb_stb <= 1'b0;
    wb_cyc <= 1'b0;
    wb_we  <= 1'b0;
    if (!acked) begin
      abort_on_timeout("wb_ack");
    end
  endtask

  task automatic write_reg(input voice_reg_addr_t addr, input logic [15:0] data);
    logic [15:0] unused;
    bus_cycle(addr, 1'b1, data, unused);
  endtask

  task automatic check_reg(input voice_reg_addr_t addr, input logic [15:0] expected);
    logic [15:0] data;
    bus_cycle(addr, 1'b0, '0, data);
    check_value(addr.name(), data, expected);
  endtask

  task automatic wait_sample(output logic [15:0] value);
    int   cycles;
    logic seen;
    seen  = 1'b0;
    value = '0;
    for (cycles = 0; cycles < SAMPLE_TIMEOUT && !seen; cycles++) begin
      @(posedge clock_50_000_000);
      if (sample_valid) begin
        seen  = 1'b1;
        value = sample;
      end
    end
    if (!seen) begin
      abort_on_timeout("sample_valid");
    end
  endtask

  task automatic wait_envelope_end();
    int   cycles;
    logic seen;
    seen = 1'b0;
    for (cycles = 0; cycles < END_TIMEOUT && !seen; cycles++) begin
      @(posedge clock_50_000_000);
      seen = envelope_end;
    end
    if (!seen) begin
      abort_on_timeout("envelope_end");
    end
  endtask

  // Polls STATUS once per sample until the envelope reaches the state
  task automatic wait_for_state(input envelope_state_t target);
    logic [15:0] status;
    logic [15:0] ignored;
    int          samples;
    samples = 0;
    bus_cycle(STATUS, 1'b0, '0, status);
    while (status[2:0] != target && samples < STATE_TIMEOUT) begin
      wait_sample(ignored);
      bus_cycle(STATUS, 1'b0, '0, status);
      samples++;
    end
    if (status[2:0] != target) begin
      abort_on_timeout({"envelope state ", target.name()});
    end
  endtask

  task automatic start_test();
    test_errors    = 0;
    assertion_mark = synth_voice_inst.synth_voice_sva_inst.failure_count;
  endtask

  task automatic finish_test(input string name);
    int errors;
    @(negedge clock_50_000_000);
    errors = test_errors + synth_voice_inst.synth_voice_sva_inst.failure_count -
             assertion_mark;
    total_errors += errors;
    if (errors != 0) begin
      failed_tests++;
    end
    $display("%s: finished with %0d errors", name, errors);
  endtask

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    reset_l      = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    wb_we        = 1'b0;
    wb_stb       = 1'b0;
    wb_cyc       = 1'b0;
    failed_tests = 0;
    total_errors = 0;
    repeat (3) @(posedge clock_50_000_000);
    reset_l <= 1'b1;

    start_test();
    @(posedge clock_50_000_000);
    check_value("wb_ack after reset", 16'(wb_ack), 16'd0);
    check_value("envelope_level after reset", envelope_level, 16'd0);
    finish_test("Reset values");

    start_test();
    attack_setting  = random_rate();
    decay_setting   = random_rate();
    sustain_setting = 16'($random(seed)) | 16'h4000;
    release_setting = random_rate();
    step_setting    = 16'($random(seed));
    write_reg(ATTACK_RATE, attack_setting);
    write_reg(DECAY_RATE, decay_setting);
    write_reg(SUSTAIN_LEVEL, sustain_setting);
    write_reg(RELEASE_RATE, release_setting);
    write_reg(PHASE_STEP, step_setting);
    write_reg(WAVEFORM, 16'd3);
    check_reg(ATTACK_RATE, attack_setting);
    check_reg(DECAY_RATE, decay_setting);
    check_reg(SUSTAIN_LEVEL, sustain_setting);
    check_reg(RELEASE_RATE, release_setting);
    check_reg(PHASE_STEP, step_setting);
    check_reg(WAVEFORM, SAW);
    write_reg(WAVEFORM, TRIANGLE);
    check_reg(WAVEFORM, TRIANGLE);
    finish_test("Wishbone register readback");

    start_test();
    write_reg(WAVEFORM, SAW);
    write_reg(NOTE, 16'd1);
    wait_for_state(SUSTAIN);
    finish_test("Attack and decay");

    start_test();
    repeat (4) wait_sample(sample_value);
    check_value("sustained envelope_level", envelope_level, sustain_setting);
    write_reg(NOTE, 16'd0);
    wait_envelope_end();
    check_reg(STATUS, IDLE);
    check_value("envelope_level after release", envelope_level, 16'd0);
    finish_test("Sustain and release");

    // Full level sawtooth, then silence once the note has ended
    start_test();
    write_reg(SUSTAIN_LEVEL, 16'hFFFF);
    write_reg(NOTE, 16'd1);
    wait_for_state(SUSTAIN);
    repeat (8) wait_sample(sample_value);
    write_reg(NOTE, 16'd0);
    wait_envelope_end();
    wait_sample(sample_value);
    check_value("sample at level zero", sample_value, 16'd0);
    finish_test("Oscillator samples");

    start_test();
    write_reg(NOTE, 16'd1);
    wait_for_state(SUSTAIN);
    write_reg(NOTE, 16'd0);
    check_reg(STATUS, RELEASE);
    write_reg(NOTE, 16'd1);
    check_reg(STATUS, ATTACK);
    check_value("envelope_level after retrigger", envelope_level, 16'd0);
    finish_test("Retrigger during release");

    $display("Tests run: 6, tests with errors: %0d, total errors: %0d",
             failed_tests, total_errors);
    if (total_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : synth_voice_tb

// ==== synth_voice.f ====
+incdir+include
src/envelope_pkg.sv
src/voice_reg_pkg.sv
src/voice_registers.sv
src/envelope_generator.sv
src/tone_oscillator.sv
src/synth_voice.sv
verification/synth_voice_sva.sv
verification/synth_voice_tb.sv
